// File: vec_defs.svh
//////////////////////////////////////////////////
// sizes for the two-lane vector slice
// offsets and vl share one width, so vl tops out at 64
//////////////////////////////////////////////////
`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

// register file geometry
`define VEC_NUM_REGS 32
`define VEC_REG_BITS 128
`define VEC_REG_IDX_BITS $clog2(`VEC_NUM_REGS)

// elements handled per cycle, widest element is one lane word
`define VEC_LANES 2
`define VEC_ELEM_BITS 32

// element offset and vl, 0 to 64
`define VEC_OFF_BITS 7

`endif

// File: vec_pkg.sv
//////////////////////////////////////////////////
// element width and ALU op types
// sew codes equal log2 of the element size in bytes
//////////////////////////////////////////////////
`include "vec_defs.svh"

package vec_pkg;

  // code 3 is unused
  typedef enum logic [1:0] {
    sew8  = 2'd0,
    sew16 = 2'd1,
    sew32 = 2'd2
  } sew_t;

  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4
  } valu_op_t;

  // keep only the low sew bits of a lane word
  function automatic logic [`VEC_ELEM_BITS-1:0] sew_trunc(input sew_t s,
      input logic [`VEC_ELEM_BITS-1:0] v);
    case (s)
      sew8:    return {{(`VEC_ELEM_BITS-8){1'b0}}, v[7:0]};
      sew16:   return {{(`VEC_ELEM_BITS-16){1'b0}}, v[15:0]};
      default: return v;
    endcase
  endfunction

endpackage

// File: vec_elem_seq.sv
//////////////////////////////////////////////////
// walks element offsets two per cycle up to vl
// instruction fields are held until the next start
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_elem_seq (
  input  logic                           CLK,
  input  logic                           nRST,
  input  logic                           start,
  input  vec_pkg::valu_op_t              op,
  input  vec_pkg::sew_t                  sew,
  input  logic [`VEC_OFF_BITS-1:0]       vl,
  input  logic [`VEC_REG_IDX_BITS-1:0]   vd,
  input  logic [`VEC_REG_IDX_BITS-1:0]   vs1,
  input  logic [`VEC_REG_IDX_BITS-1:0]   vs2,
  input  logic                           vm,
  input  logic                           done,
  output logic                           busy,
  output logic                           issue,
  output logic                           last,
  output logic [`VEC_OFF_BITS-1:0]       elem_off0,
  output logic [`VEC_OFF_BITS-1:0]       elem_off1,
  output vec_pkg::valu_op_t              cur_op,
  output vec_pkg::sew_t                  cur_sew,
  output logic [`VEC_OFF_BITS-1:0]       cur_vl,
  output logic [`VEC_REG_IDX_BITS-1:0]   cur_vd,
  output logic [`VEC_REG_IDX_BITS-1:0]   cur_vs1,
  output logic [`VEC_REG_IDX_BITS-1:0]   cur_vs2,
  output logic                           cur_vm
);

  logic                     busy_q;
  logic                     issue_q;
  logic                     empty_q;
  logic [`VEC_OFF_BITS-1:0] off_q;
  logic [`VEC_OFF_BITS-1:0] next_off;

  assign next_off  = off_q + `VEC_OFF_BITS'(`VEC_LANES);
  assign issue     = issue_q;
  assign elem_off0 = off_q;
  assign elem_off1 = off_q + `VEC_OFF_BITS'(1);

  // an empty instruction still signals last once so the ALU can finish it
  assign last = (issue_q & (next_off >= cur_vl)) | empty_q;

  // busy drops in the same cycle as done
  assign busy = busy_q & ~done;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy_q  <= 1'b0;
      issue_q <= 1'b0;
      empty_q <= 1'b0;
      off_q   <= '0;
    end else begin
      empty_q <= 1'b0;
      if (start && !busy) begin
        busy_q  <= 1'b1;
        issue_q <= (vl != '0);
        empty_q <= (vl == '0);
        off_q   <= '0;
      end else begin
        if (done) begin
          busy_q <= 1'b0;
        end
        if (issue_q) begin
          off_q <= next_off;
          if (last) begin
            issue_q <= 1'b0;
          end
        end
      end
    end
  end

  // captured instruction
  always_ff @(posedge CLK) begin
    if (start && !busy) begin
      cur_op  <= op;
      cur_sew <= sew;
      cur_vl  <= vl;
      cur_vd  <= vd;
      cur_vs1 <= vs1;
      cur_vs2 <= vs2;
      cur_vm  <= vm;
    end
  end

endmodule

// File: vec_reg_file.sv
//////////////////////////////////////////////////
// 32 x 128 bit vector registers, two element lanes
// element reads are combinational, a read of the element
// being written in the same cycle returns the old value
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_reg_file (
  input  logic                                          CLK,
  input  logic                                          nRST,
  input  vec_pkg::sew_t                                 sew,
  input  logic [`VEC_OFF_BITS-1:0]                      vl,
  input  logic [`VEC_REG_IDX_BITS-1:0]                  vs1,
  input  logic [`VEC_REG_IDX_BITS-1:0]                  vs2,
  input  logic [`VEC_REG_IDX_BITS-1:0]                  vd,
  input  logic [`VEC_OFF_BITS-1:0]                      rd_off0,
  input  logic [`VEC_OFF_BITS-1:0]                      rd_off1,
  input  logic [`VEC_LANES-1:0]                         wen,
  input  logic [`VEC_OFF_BITS-1:0]                      wr_off0,
  input  logic [`VEC_OFF_BITS-1:0]                      wr_off1,
  input  logic [`VEC_LANES-1:0][`VEC_ELEM_BITS-1:0]     w_data,
  input  logic                                          load_en,
  input  logic [`VEC_REG_IDX_BITS-1:0]                  load_reg,
  input  logic [`VEC_REG_BITS-1:0]                      load_data,
  input  logic [`VEC_REG_IDX_BITS-1:0]                  rd_reg,
  output logic [`VEC_LANES-1:0][`VEC_ELEM_BITS-1:0]     vs1_data,
  output logic [`VEC_LANES-1:0][`VEC_ELEM_BITS-1:0]     vs2_data,
  output logic [`VEC_LANES-1:0]                         mask,
  output logic [`VEC_REG_BITS-1:0]                      rd_data
);

  localparam int REG_BYTES  = `VEC_REG_BITS / 8;
  localparam int POS_BITS   = $clog2(REG_BYTES);
  localparam int ELEM_BYTES = `VEC_ELEM_BITS / 8;

  logic [`VEC_NUM_REGS-1:0][`VEC_REG_BITS-1:0] regs;
  logic [`VEC_LANES-1:0][`VEC_OFF_BITS-1:0]    rd_off;
  logic [`VEC_LANES-1:0][`VEC_OFF_BITS-1:0]    wr_off;

  assign rd_off = {rd_off1, rd_off0};
  assign wr_off = {wr_off1, wr_off0};

  // register holding the element, offsets past one register
  // spill into the ones after base
  function automatic logic [`VEC_REG_IDX_BITS-1:0] elem_reg(
      input logic [`VEC_REG_IDX_BITS-1:0] base,
      input logic [`VEC_OFF_BITS-1:0] off,
      input vec_pkg::sew_t s);
    logic [`VEC_OFF_BITS-1:0] grp;
    grp = off >> (POS_BITS - int'(s));
    return base + grp[`VEC_REG_IDX_BITS-1:0];
  endfunction

  // first byte of the element inside its register
  function automatic logic [POS_BITS-1:0] elem_pos(
      input logic [`VEC_OFF_BITS-1:0] off,
      input vec_pkg::sew_t s);
    logic [`VEC_OFF_BITS-1:0] scaled;
    scaled = off << int'(s);
    return scaled[POS_BITS-1:0];
  endfunction

  // zero extended element read
  function automatic logic [`VEC_ELEM_BITS-1:0] elem_read(
      input logic [`VEC_REG_IDX_BITS-1:0] base,
      input logic [`VEC_OFF_BITS-1:0] off,
      input vec_pkg::sew_t s);
    logic [`VEC_REG_BITS-1:0] shifted;
    shifted = regs[elem_reg(base, off, s)] >> (8 * int'(elem_pos(off, s)));
    return vec_pkg::sew_trunc(s, shifted[`VEC_ELEM_BITS-1:0]);
  endfunction

  always_comb begin
    for (int l = 0; l < `VEC_LANES; l++) begin
      vs1_data[l] = elem_read(vs1, rd_off[l], sew);
      vs2_data[l] = elem_read(vs2, rd_off[l], sew);
      // one mask bit per element, counted from bit 0 of v0
      mask[l]     = regs[0][rd_off[l]];
    end
  end

  assign rd_data = regs[rd_reg];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '0;
    end else begin
      for (int l = 0; l < `VEC_LANES; l++) begin
        if (wen[l] && (wr_off[l] < vl)) begin
          // only the bytes of one element are touched
          for (int b = 0; b < ELEM_BYTES; b++) begin
            if (b < (1 << int'(sew))) begin
              regs[elem_reg(vd, wr_off[l], sew)][8*(int'(elem_pos(wr_off[l], sew)) + b) +: 8]
                <= w_data[l][8*b +: 8];
            end
          end
        end
      end
      // host load replaces the whole register
      if (load_en) begin
        regs[load_reg] <= load_data;
      end
    end
  end

endmodule

// File: vec_lane_alu.sv
//////////////////////////////////////////////////
// two-lane integer ALU, results written one cycle after issue
// op and sew are read from the held instruction
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_lane_alu (
  input  logic                                        CLK,
  input  logic                                        nRST,
  input  logic                                        issue,
  input  logic                                        last,
  input  vec_pkg::valu_op_t                           op,
  input  vec_pkg::sew_t                               sew,
  input  logic                                        vm,
  input  logic [`VEC_OFF_BITS-1:0]                    vl,
  input  logic [`VEC_OFF_BITS-1:0]                    elem_off0,
  input  logic [`VEC_OFF_BITS-1:0]                    elem_off1,
  input  logic [`VEC_LANES-1:0][`VEC_ELEM_BITS-1:0]   vs1_data,
  input  logic [`VEC_LANES-1:0][`VEC_ELEM_BITS-1:0]   vs2_data,
  input  logic [`VEC_LANES-1:0]                       mask,
  output logic [`VEC_LANES-1:0]                       wen,
  output logic [`VEC_OFF_BITS-1:0]                    wr_off0,
  output logic [`VEC_OFF_BITS-1:0]                    wr_off1,
  output logic [`VEC_LANES-1:0][`VEC_ELEM_BITS-1:0]   w_data,
  output logic                                        done
);

  logic [`VEC_LANES-1:0]                     lane_en;
  logic [`VEC_LANES-1:0][`VEC_ELEM_BITS-1:0] a_q;
  logic [`VEC_LANES-1:0][`VEC_ELEM_BITS-1:0] b_q;
  logic                                      wb_last_q;

  // masked off lanes never reach the register file
  assign lane_en[0] = issue & (vm | mask[0]);
  // odd vl leaves lane 1 past the end on the final group
  assign lane_en[1] = issue & (vm | mask[1]) & (elem_off1 < vl);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wen       <= '0;
      wb_last_q <= 1'b0;
      done      <= 1'b0;
    end else begin
      wen       <= lane_en;
      wb_last_q <= issue & last;
      // vl=0 has no write-back, so done follows last directly
      done      <= wb_last_q | (last & ~issue);
    end
  end

  always_ff @(posedge CLK) begin
    if (issue) begin
      a_q     <= vs2_data;
      b_q     <= vs1_data;
      wr_off0 <= elem_off0;
      wr_off1 <= elem_off1;
    end
  end

  // vs2 op vs1
  always_comb begin
    for (int l = 0; l < `VEC_LANES; l++) begin
      case (op)
        vec_pkg::op_add: w_data[l] = a_q[l] + b_q[l];
        vec_pkg::op_sub: w_data[l] = a_q[l] - b_q[l];
        vec_pkg::op_and: w_data[l] = a_q[l] & b_q[l];
        vec_pkg::op_or:  w_data[l] = a_q[l] | b_q[l];
        vec_pkg::op_xor: w_data[l] = a_q[l] ^ b_q[l];
        default:         w_data[l] = '0;
      endcase
      // carries and borrows above sew are dropped
      w_data[l] = vec_pkg::sew_trunc(sew, w_data[l]);
    end
  end

endmodule

// File: vec_unit.sv
//////////////////////////////////////////////////
// vector slice top, one instruction at a time
// start is ignored while busy, no host loads while busy
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_unit (
  input  logic                           CLK,
  input  logic                           nRST,
  input  logic                           start,
  input  vec_pkg::valu_op_t              op,
  input  vec_pkg::sew_t                  sew,
  input  logic [`VEC_OFF_BITS-1:0]       vl,
  input  logic [`VEC_REG_IDX_BITS-1:0]   vd,
  input  logic [`VEC_REG_IDX_BITS-1:0]   vs1,
  input  logic [`VEC_REG_IDX_BITS-1:0]   vs2,
  input  logic                           vm,
  input  logic                           load_en,
  input  logic [`VEC_REG_IDX_BITS-1:0]   load_reg,
  input  logic [`VEC_REG_BITS-1:0]       load_data,
  input  logic [`VEC_REG_IDX_BITS-1:0]   rd_reg,
  output logic [`VEC_REG_BITS-1:0]       rd_data,
  output logic                           busy,
  output logic                           done
);

  logic                                      issue;
  logic                                      last;
  logic [`VEC_OFF_BITS-1:0]                  elem_off0;
  logic [`VEC_OFF_BITS-1:0]                  elem_off1;
  vec_pkg::valu_op_t                         cur_op;
  vec_pkg::sew_t                             cur_sew;
  logic [`VEC_OFF_BITS-1:0]                  cur_vl;
  logic [`VEC_REG_IDX_BITS-1:0]              cur_vd;
  logic [`VEC_REG_IDX_BITS-1:0]              cur_vs1;
  logic [`VEC_REG_IDX_BITS-1:0]              cur_vs2;
  logic                                      cur_vm;
  logic [`VEC_LANES-1:0][`VEC_ELEM_BITS-1:0] vs1_data;
  logic [`VEC_LANES-1:0][`VEC_ELEM_BITS-1:0] vs2_data;
  logic [`VEC_LANES-1:0]                     mask;
  logic [`VEC_LANES-1:0]                     wen;
  logic [`VEC_OFF_BITS-1:0]                  wr_off0;
  logic [`VEC_OFF_BITS-1:0]                  wr_off1;
  logic [`VEC_LANES-1:0][`VEC_ELEM_BITS-1:0] w_data;

  vec_elem_seq u_seq (
    .CLK(CLK), .nRST(nRST), .start(start), .op(op), .sew(sew), .vl(vl),
    .vd(vd), .vs1(vs1), .vs2(vs2), .vm(vm), .done(done),
    .busy(busy), .issue(issue), .last(last),
    .elem_off0(elem_off0), .elem_off1(elem_off1),
    .cur_op(cur_op), .cur_sew(cur_sew), .cur_vl(cur_vl), .cur_vd(cur_vd),
    .cur_vs1(cur_vs1), .cur_vs2(cur_vs2), .cur_vm(cur_vm)
  );

  // reads follow the issuing group, writes the group before it
  vec_reg_file u_rf (
    .CLK(CLK), .nRST(nRST), .sew(cur_sew), .vl(cur_vl),
    .vs1(cur_vs1), .vs2(cur_vs2), .vd(cur_vd),
    .rd_off0(elem_off0), .rd_off1(elem_off1),
    .wen(wen), .wr_off0(wr_off0), .wr_off1(wr_off1), .w_data(w_data),
    .load_en(load_en), .load_reg(load_reg), .load_data(load_data),
    .rd_reg(rd_reg), .vs1_data(vs1_data), .vs2_data(vs2_data),
    .mask(mask), .rd_data(rd_data)
  );

  vec_lane_alu u_alu (
    .CLK(CLK), .nRST(nRST), .issue(issue), .last(last),
    .op(cur_op), .sew(cur_sew), .vm(cur_vm), .vl(cur_vl),
    .elem_off0(elem_off0), .elem_off1(elem_off1),
    .vs1_data(vs1_data), .vs2_data(vs2_data), .mask(mask),
    .wen(wen), .wr_off0(wr_off0), .wr_off1(wr_off1), .w_data(w_data),
    .done(done)
  );

endmodule

// File: tb_vec_unit.sv
//////////////////////////////////////////////////
// self-checking testbench, commands come from
// vec_patterns.txt in the directory the run starts in
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vec_defs.svh"

module tb_vec_unit;

  localparam int CLK_PERIOD      = 20;
  localparam int NAME_CHARS      = 24;
  localparam int CYCLES_PER_LINE = 100;
  localparam int DONE_LIMIT      = 64;

  logic                         CLK;
  logic                         nRST;
  logic                         start;
  vec_pkg::valu_op_t            op;
  vec_pkg::sew_t                sew;
  logic [`VEC_OFF_BITS-1:0]     vl;
  logic [`VEC_REG_IDX_BITS-1:0] vd;
  logic [`VEC_REG_IDX_BITS-1:0] vs1;
  logic [`VEC_REG_IDX_BITS-1:0] vs2;
  logic                         vm;
  logic                         load_en;
  logic [`VEC_REG_IDX_BITS-1:0] load_reg;
  logic [`VEC_REG_BITS-1:0]     load_data;
  logic [`VEC_REG_IDX_BITS-1:0] rd_reg;
  logic [`VEC_REG_BITS-1:0]     rd_data;
  logic                         busy;
  logic                         done;

  vec_unit dut (
    .CLK(CLK), .nRST(nRST), .start(start), .op(op), .sew(sew), .vl(vl),
    .vd(vd), .vs1(vs1), .vs2(vs2), .vm(vm),
    .load_en(load_en), .load_reg(load_reg), .load_data(load_data),
    .rd_reg(rd_reg), .rd_data(rd_data), .busy(busy), .done(done)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  task automatic abort_run(input string reason);
    $display("%0s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_reg(input string name, input logic [`VEC_REG_BITS-1:0] exp,
      input logic [`VEC_REG_BITS-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %0s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("ERR %0s expected %0d cycles actual %0d cycles", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %0s expected %b actual %b", name, exp, act));
    end
  endtask

  // whole register through the combinational read port
  task automatic read_reg(input logic [`VEC_REG_IDX_BITS-1:0] r,
      output logic [`VEC_REG_BITS-1:0] data);
    @(posedge CLK);
    rd_reg <= r;
    @(negedge CLK);
    data = rd_data;
  endtask

  task automatic host_load(input logic [`VEC_REG_IDX_BITS-1:0] r,
      input logic [`VEC_REG_BITS-1:0] data);
    @(posedge CLK);
    load_en   <= 1'b1;
    load_reg  <= r;
    load_data <= data;
    @(posedge CLK);
    load_en   <= 1'b0;
  endtask

  // one instruction, cycles counted from the start cycle to the done cycle
  task automatic run_instr(input string name, input logic [2:0] op_code,
      input logic [1:0] sew_code, input logic [`VEC_OFF_BITS-1:0] f_vl,
      input logic [`VEC_REG_IDX_BITS-1:0] f_vd, input logic [`VEC_REG_IDX_BITS-1:0] f_vs1,
      input logic [`VEC_REG_IDX_BITS-1:0] f_vs2, input logic f_vm);
    int cycles;
    int exp_cycles;
    exp_cycles = (int'(f_vl) + 1) / 2 + 2;
    @(posedge CLK);
    start <= 1'b1;
    op    <= vec_pkg::valu_op_t'(op_code);
    sew   <= vec_pkg::sew_t'(sew_code);
    vl    <= f_vl;
    vd    <= f_vd;
    vs1   <= f_vs1;
    vs2   <= f_vs2;
    vm    <= f_vm;
    cycles = 0;
    do begin
      @(posedge CLK);
      start <= 1'b0;
      cycles++;
      @(negedge CLK);
      // busy from the cycle after start, low again in the done cycle
      check_flag($sformatf("%0s_busy", name), cycles < exp_cycles, busy);
      if (!done && cycles > DONE_LIMIT) begin
        abort_run($sformatf("done never arrived for instruction %0s", name));
      end
    end while (!done);
    check_cycles(name, exp_cycles, cycles);
  endtask

  initial begin
    int                           fd;
    int                           n;
    logic [7:0]                   cmd;
    logic [8*NAME_CHARS-1:0]      name;
    logic [8*128-1:0]             line_buf;
    logic [2:0]                   op_code;
    logic [1:0]                   sew_code;
    logic [`VEC_OFF_BITS-1:0]     f_vl;
    logic [`VEC_REG_IDX_BITS-1:0] f_reg;
    logic [`VEC_REG_IDX_BITS-1:0] f_vs1;
    logic [`VEC_REG_IDX_BITS-1:0] f_vs2;
    logic                         f_vm;
    logic [`VEC_REG_BITS-1:0]     exp_val;
    logic [`VEC_REG_BITS-1:0]     act;
    nRST      = 1'b0;
    start     = 1'b0;
    op        = vec_pkg::op_add;
    sew       = vec_pkg::sew8;
    vl        = '0;
    vd        = '0;
    vs1       = '0;
    vs2       = '0;
    vm        = 1'b1;
    load_en   = 1'b0;
    load_reg  = '0;
    load_data = '0;
    rd_reg    = '0;
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    // every register comes out of reset cleared
    for (int r = 0; r < `VEC_NUM_REGS; r++) begin
      read_reg(r[`VEC_REG_IDX_BITS-1:0], act);
      check_reg($sformatf("reset_zero_v%0d", r), '0, act);
    end
    fd = $fopen("vec_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open vec_patterns.txt");
    end
    while ($fscanf(fd, " %c", cmd) == 1) begin
      case (cmd)
        "#": n = $fgets(line_buf, fd);
        "L": begin
          n = $fscanf(fd, "%d %h", f_reg, exp_val);
          if (n != 2) begin
            abort_run("malformed load line in pattern file");
          end
          host_load(f_reg, exp_val);
        end
        "X": begin
          n = $fscanf(fd, "%s %d %d %d %d %d %d %d", name, op_code, sew_code, f_vl,
                      f_reg, f_vs1, f_vs2, f_vm);
          if (n != 8) begin
            abort_run("malformed execute line in pattern file");
          end
          run_instr($sformatf("%0s", name), op_code, sew_code, f_vl, f_reg, f_vs1, f_vs2,
                    f_vm);
        end
        "C": begin
          n = $fscanf(fd, "%s %d %h", name, f_reg, exp_val);
          if (n != 3) begin
            abort_run("malformed check line in pattern file");
          end
          read_reg(f_reg, act);
          check_reg($sformatf("%0s", name), exp_val, act);
        end
        default: abort_run($sformatf("unknown command %c in pattern file", cmd));
      endcase
    end
    $fclose(fd);
    $display("Test completed successfully");
    $finish;
  end

  // budget of cycles per pattern line, plus one share for the reset sweep
  initial begin
    int               wfd;
    int               lines;
    logic [8*128-1:0] wbuf;
    lines = 0;
    wfd = $fopen("vec_patterns.txt", "r");
    if (wfd != 0) begin
      while ($fgets(wbuf, wfd) != 0) begin
        lines++;
      end
      $fclose(wfd);
    end
    repeat ((lines + 1) * CYCLES_PER_LINE) @(posedge CLK);
    abort_run($sformatf("run timed out after %0d cycles", (lines + 1) * CYCLES_PER_LINE));
  end

endmodule

// File: vec_patterns.txt
# L reg hex | X name op sew vl vd vs1 vs2 vm | C name reg hex
# op 0 add 1 sub 2 and 3 or 4 xor, sew 0 e8 1 e16 2 e32, vm 1 unmasked
L 1 ffffffff7fffffff0000000200000001
L 2 00000002000000010000002000000010
C load_v1 1 ffffffff7fffffff0000000200000001
C load_v2 2 00000002000000010000002000000010
X add_e32 0 2 4 3 1 2 1
C add_e32 3 00000001800000000000002200000011
L 4 aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa
X sub_e32_vl3 1 2 3 4 1 2 1
C sub_e32_vl3 4 aaaaaaaa800000020000001e0000000f
L 5 0123456789abcdeffedcba9876543210
L 6 ffff0000f0f00f0f55aa33cc00ff1234
X and_e16 2 1 8 7 6 5 1
C and_e16 7 0123000080a00d0f5488328800541210
X or_e16_vl5 3 1 5 8 6 5 1
C or_e16_vl5 8 000000000000cfeffffebbdc76ff3234
X xor_e16 4 1 8 9 6 5 1
C xor_e16 9 fedc4567795bc2e0ab76895476ab2024
X sub_e16 1 1 2 10 5 6 1
C sub_e16 10 0000000000000000000000008aabe024
L 11 0f0e0d0c0b0a09080706050403020100
L 12 1f1e1d1c1b1a19181716151413121110
L 13 2f2e2d2c2b2a29282726252423222120
L 14 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0
L 15 01010101010101010101010101010101
L 16 80808080808080808080808080808080
L 19 55555555555555555555555555555555
X add_e8_vl40 0 0 40 17 14 11 1
C add_e8_vl40_g0 17 fffefdfcfbfaf9f8f7f6f5f4f3f2f1f0
C add_e8_vl40_g1 18 201f1e1d1c1b1a191817161514131211
C add_e8_vl40_g2 19 5555555555555555a7a6a5a4a3a2a1a0
X sub_e8 1 0 16 24 14 11 1
C sub_e8 24 1f1e1d1c1b1a19181716151413121110
L 0 00000000000000000000000000000005
L 20 11111111111111111111111111111111
X xor_e32_masked 4 2 4 20 2 1 0
C xor_e32_masked 20 111111117ffffffe1111111100000011
X and_e8_unmasked 2 0 3 21 6 5 1
C and_e8_unmasked 21 00000000000000000000000000541210
X and_e8_masked 2 0 3 22 6 5 0
C and_e8_masked 22 00000000000000000000000000540010
L 23 0123456789abcdef0123456789abcdef
X add_vl0 0 2 0 23 1 2 1
C add_vl0 23 0123456789abcdef0123456789abcdef

// File: verilog.f
+incdir+.
vec_pkg.sv
vec_elem_seq.sv
vec_reg_file.sv
vec_lane_alu.sv
vec_unit.sv
tb_vec_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vec_unit
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
